/* common/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data path width in bits
`define WORD_W 32

// Number of architectural registers
`define REG_COUNT 32

// Width of a register specifier in the instruction word
`define REG_ADDR_W 5

`endif

/* common/cpu_types_pkg.sv */
package cpu_types_pkg;

	`include "cpu_config.svh"

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] regbits_t;

	// Major opcodes in instruction bits 31:26
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		ADDIU = 6'h09,
		SLTI  = 6'h0A,
		ANDI  = 6'h0C,
		ORI   = 6'h0D,
		XORI  = 6'h0E,
		LUI   = 6'h0F,
		HALT  = 6'h3F
	} opcode_t;

	// R-type function codes in instruction bits 5:0
	typedef enum logic [5:0] {
		SLL  = 6'h00,
		SRL  = 6'h02,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2A,
		SLTU = 6'h2B
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd5,
		ALU_SLT  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_SLL  = 4'd8,
		ALU_SRL  = 4'd9,
		ALU_LUI  = 4'd10
	} aluop_t;

	// Second ALU operand comes from rt data or the extended immediate
	typedef enum logic {
		SEL_REG_DATA = 1'b0,
		SEL_IMM      = 1'b1
	} alu_source_mux_selection;

	// R-types write rd, I-types write rt
	typedef enum logic {
		SEL_RD = 1'b0,
		SEL_RT = 1'b1
	} reg_dest_mux_selection;

endpackage

/* decode/control_unit.sv */
`timescale 1ns/1ps

`include "cpu_config.svh"

module control_unit import cpu_types_pkg::*; (
	input  word_t                   instr,
	output aluop_t                  alu_op,
	output alu_source_mux_selection alu_src,
	output reg_dest_mux_selection   reg_dest,
	output logic                    wen,
	output logic                    halt,
	output word_t                   imm_ext
);

	opcode_t opcode;
	funct_t funct;
	logic [15:0] imm16;
	word_t imm_sign;
	word_t imm_zero;

	assign opcode = opcode_t'(instr[31:26]);
	assign funct = funct_t'(instr[5:0]);
	assign imm16 = instr[15:0];
	assign imm_sign = {{(`WORD_W-16){imm16[15]}}, imm16};
	assign imm_zero = {{(`WORD_W-16){1'b0}}, imm16};

	always_comb begin
		// Defaults describe a bubble that writes nothing
		alu_op = ALU_ADD;
		alu_src = SEL_REG_DATA;
		reg_dest = SEL_RD;
		wen = 1'b0;
		halt = 1'b0;
		imm_ext = imm_sign;

		case (opcode)
			RTYPE: begin
				wen = 1'b1;
				case (funct)
					ADDU: alu_op = ALU_ADD;
					SUBU: alu_op = ALU_SUB;
					AND:  alu_op = ALU_AND;
					OR:   alu_op = ALU_OR;
					XOR:  alu_op = ALU_XOR;
					NOR:  alu_op = ALU_NOR;
					SLT:  alu_op = ALU_SLT;
					SLTU: alu_op = ALU_SLTU;
					SLL:  alu_op = ALU_SLL;
					SRL:  alu_op = ALU_SRL;
					default: wen = 1'b0; // Unknown funct falls back to a bubble
				endcase
			end
			ADDIU, SLTI, LUI: begin
				wen = 1'b1;
				alu_src = SEL_IMM;
				reg_dest = SEL_RT;
				if (opcode == ADDIU) begin
					alu_op = ALU_ADD;
				end else if (opcode == SLTI) begin
					alu_op = ALU_SLT;
				end else begin
					alu_op = ALU_LUI;
				end
			end
			ANDI, ORI, XORI: begin
				// Logical immediates are zero extended
				wen = 1'b1;
				alu_src = SEL_IMM;
				reg_dest = SEL_RT;
				imm_ext = imm_zero;
				if (opcode == ANDI) begin
					alu_op = ALU_AND;
				end else if (opcode == ORI) begin
					alu_op = ALU_OR;
				end else begin
					alu_op = ALU_XOR;
				end
			end
			HALT: begin
				halt = 1'b1; // Travels down the pipe with wen low
			end
			default: begin
			end
		endcase
	end

endmodule

/* decode/register_file.sv */
`timescale 1ns/1ps

`include "cpu_config.svh"

module register_file import cpu_types_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  regbits_t rs,
	input  regbits_t rt,
	input  regbits_t waddr,
	input  word_t    wdata,
	input  logic     wen,
	output word_t    rdat1,
	output word_t    rdat2
);

	word_t regs [`REG_COUNT];

	// One read path shared by both ports, with the pending write forwarded
	function automatic word_t read_port(input regbits_t addr);
		word_t data;
		data = regs[addr]; // Register 0 is reset to zero and never written
		if (wen && (waddr == addr) && (addr != '0)) begin
			data = wdata; // Same-cycle write is visible to the reader
		end
		return data;
	endfunction

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata; // Register 0 is never written
		end
	end

	always_comb begin
		rdat1 = read_port(rs);
		rdat2 = read_port(rt);
	end

	// Register 0 reads as zero on both ports, even with a write aimed at it
	zero_reg_reads_zero: assert property (
		@(posedge CLK) disable iff (!nRST)
		((rs != '0) || (rdat1 == '0)) && ((rt != '0) || (rdat2 == '0))
	);

endmodule

/* logic/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import cpu_types_pkg::*; (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    in_valid,
	input  logic                    flush,
	input  logic                    out_ready,
	input  aluop_t                  alu_op,
	input  alu_source_mux_selection alu_src,
	input  reg_dest_mux_selection   reg_dest,
	input  logic                    wen,
	input  logic                    halt,
	input  regbits_t                rt,
	input  regbits_t                rd,
	input  logic [4:0]              shamt,
	input  word_t                   rdat1,
	input  word_t                   rdat2,
	input  word_t                   imm_ext,
	output logic                    in_ready,
	output logic                    out_valid,
	output logic                    halted,
	output aluop_t                  alu_op_id_ex,
	output alu_source_mux_selection alu_src_id_ex,
	output reg_dest_mux_selection   reg_dest_id_ex,
	output logic                    wen_id_ex,
	output logic                    halt_id_ex,
	output regbits_t                rt_id_ex,
	output regbits_t                rd_id_ex,
	output logic [4:0]              shamt_id_ex,
	output word_t                   rdat1_id_ex,
	output word_t                   rdat2_id_ex,
	output word_t                   imm_ext_id_ex
);

	logic valid_reg, valid_nxt;
	logic halted_reg, halted_nxt;
	logic wen_reg, wen_nxt;
	logic halt_reg, halt_nxt;
	aluop_t alu_op_reg, alu_op_nxt;
	alu_source_mux_selection alu_src_reg, alu_src_nxt;
	reg_dest_mux_selection reg_dest_reg, reg_dest_nxt;
	regbits_t rt_reg, rt_nxt;
	regbits_t rd_reg, rd_nxt;
	logic [4:0] shamt_reg, shamt_nxt;
	word_t rdat1_reg, rdat1_nxt;
	word_t rdat2_reg, rdat2_nxt;
	word_t imm_ext_reg, imm_ext_nxt;
	logic out_xfer;
	logic enable;

	assign out_xfer = valid_reg && out_ready;
	// A held HALT also closes the input so nothing slips in behind it
	assign in_ready = (!valid_reg || out_xfer) && !flush && !halted_reg
		&& !(valid_reg && halt_reg);
	assign enable = in_valid && in_ready;

	assign out_valid = valid_reg;
	assign halted = halted_reg;
	assign alu_op_id_ex = alu_op_reg;
	assign alu_src_id_ex = alu_src_reg;
	assign reg_dest_id_ex = reg_dest_reg;
	assign wen_id_ex = wen_reg;
	assign halt_id_ex = halt_reg;
	assign rt_id_ex = rt_reg;
	assign rd_id_ex = rd_reg;
	assign shamt_id_ex = shamt_reg;
	assign rdat1_id_ex = rdat1_reg;
	assign rdat2_id_ex = rdat2_reg;
	assign imm_ext_id_ex = imm_ext_reg;

	always_comb begin
		valid_nxt = valid_reg;
		halted_nxt = halted_reg || (out_xfer && halt_reg); // Sticky until reset
		wen_nxt = wen_reg;
		halt_nxt = halt_reg;
		alu_op_nxt = alu_op_reg;
		alu_src_nxt = alu_src_reg;
		reg_dest_nxt = reg_dest_reg;
		rt_nxt = rt_reg;
		rd_nxt = rd_reg;
		shamt_nxt = shamt_reg;
		rdat1_nxt = rdat1_reg;
		rdat2_nxt = rdat2_reg;
		imm_ext_nxt = imm_ext_reg;

		if (flush) begin
			valid_nxt = 1'b0; // Squashed slot becomes a bubble
			wen_nxt = 1'b0;
			halt_nxt = 1'b0;
			alu_op_nxt = ALU_ADD;
			alu_src_nxt = SEL_REG_DATA;
			reg_dest_nxt = SEL_RD;
			rt_nxt = '0;
			rd_nxt = '0;
			shamt_nxt = '0;
			rdat1_nxt = '0;
			rdat2_nxt = '0;
			imm_ext_nxt = '0;
		end else if (enable) begin
			valid_nxt = 1'b1;
			wen_nxt = wen;
			halt_nxt = halt;
			alu_op_nxt = alu_op;
			alu_src_nxt = alu_src;
			reg_dest_nxt = reg_dest;
			rt_nxt = rt;
			rd_nxt = rd;
			shamt_nxt = shamt;
			rdat1_nxt = rdat1;
			rdat2_nxt = rdat2;
			imm_ext_nxt = imm_ext;
		end else if (out_xfer) begin
			// Drained with nothing behind it
			valid_nxt = 1'b0;
			wen_nxt = 1'b0;
			halt_nxt = 1'b0;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_reg <= 1'b0;
			halted_reg <= 1'b0;
			wen_reg <= 1'b0;
			halt_reg <= 1'b0;
			alu_op_reg <= ALU_ADD;
			alu_src_reg <= SEL_REG_DATA;
			reg_dest_reg <= SEL_RD;
		end else begin
			valid_reg <= valid_nxt;
			halted_reg <= halted_nxt;
			wen_reg <= wen_nxt;
			halt_reg <= halt_nxt;
			alu_op_reg <= alu_op_nxt;
			alu_src_reg <= alu_src_nxt;
			reg_dest_reg <= reg_dest_nxt;
		end
	end

	always_ff @(posedge CLK) begin
		rt_reg <= rt_nxt;
		rd_reg <= rd_nxt;
		shamt_reg <= shamt_nxt;
		rdat1_reg <= rdat1_nxt;
		rdat2_reg <= rdat2_nxt;
		imm_ext_reg <= imm_ext_nxt;
	end

	// A stalled instruction is presented unchanged until it transfers
	payload_stable: assert property (
		@(posedge CLK) disable iff (!nRST)
		(valid_reg && !out_ready && !flush) |=> (valid_reg && $stable(wen_reg)
			&& $stable(halt_reg) && $stable(alu_op_reg) && $stable(alu_src_reg)
			&& $stable(reg_dest_reg) && $stable(rt_reg) && $stable(rd_reg)
			&& $stable(shamt_reg) && $stable(rdat1_reg) && $stable(rdat2_reg)
			&& $stable(imm_ext_reg))
	);

	no_output_after_halt: assert property (
		@(posedge CLK) disable iff (!nRST)
		halted_reg |=> !$rose(valid_reg)
	);

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import cpu_types_pkg::*; (
	input  aluop_t                  alu_op,
	input  alu_source_mux_selection alu_src,
	input  reg_dest_mux_selection   reg_dest,
	input  word_t                   rdat1,
	input  word_t                   rdat2,
	input  word_t                   imm_ext,
	input  regbits_t                rt,
	input  regbits_t                rd,
	input  logic [4:0]              shamt,
	output word_t                   result,
	output regbits_t                dest
);

	word_t op_b;

	assign op_b = (alu_src == SEL_IMM) ? imm_ext : rdat2;
	assign dest = (reg_dest == SEL_RT) ? rt : rd;

	always_comb begin
		case (alu_op)
			ALU_ADD:  result = rdat1 + op_b;
			ALU_SUB:  result = rdat1 - op_b;
			ALU_AND:  result = rdat1 & op_b;
			ALU_OR:   result = rdat1 | op_b;
			ALU_XOR:  result = rdat1 ^ op_b;
			ALU_NOR:  result = ~(rdat1 | op_b);
			ALU_SLT:  result = word_t'($signed(rdat1) < $signed(op_b));
			ALU_SLTU: result = word_t'(rdat1 < op_b);
			// Shift amount comes from the instruction, the value from rt
			ALU_SLL:  result = rdat2 << shamt;
			ALU_SRL:  result = rdat2 >> shamt;
			ALU_LUI:  result = {imm_ext[15:0], 16'h0000};
			default:  result = rdat1 + op_b;
		endcase
	end

endmodule

/* logic/mips_id_ex.sv */
`timescale 1ns/1ps

module mips_id_ex import cpu_types_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     in_valid,
	output logic     in_ready,
	input  word_t    in_instr,
	output logic     out_valid,
	input  logic     out_ready,
	output word_t    out_result,
	output regbits_t out_dest,
	output logic     out_wen,
	output logic     out_halt,
	input  logic     flush
);

	aluop_t alu_op, alu_op_id_ex;
	alu_source_mux_selection alu_src, alu_src_id_ex;
	reg_dest_mux_selection reg_dest, reg_dest_id_ex;
	logic wen, halt;
	word_t imm_ext, imm_ext_id_ex;
	word_t rdat1, rdat2, rdat1_id_ex, rdat2_id_ex;
	regbits_t rt_id_ex, rd_id_ex;
	logic [4:0] shamt_id_ex;
	logic wb_wen;

	// Write back only on the edge where the result leaves the slice
	assign wb_wen = out_valid && out_ready && out_wen;

	control_unit u_control_unit (
		.instr    (in_instr),
		.alu_op   (alu_op),
		.alu_src  (alu_src),
		.reg_dest (reg_dest),
		.wen      (wen),
		.halt     (halt),
		.imm_ext  (imm_ext)
	);

	register_file u_register_file (
		.CLK   (CLK),
		.nRST  (nRST),
		.rs    (in_instr[25:21]),
		.rt    (in_instr[20:16]),
		.waddr (out_dest),
		.wdata (out_result),
		.wen   (wb_wen),
		.rdat1 (rdat1),
		.rdat2 (rdat2)
	);

	id_ex_reg u_id_ex_reg (
		.CLK            (CLK),
		.nRST           (nRST),
		.in_valid       (in_valid),
		.flush          (flush),
		.out_ready      (out_ready),
		.alu_op         (alu_op),
		.alu_src        (alu_src),
		.reg_dest       (reg_dest),
		.wen            (wen),
		.halt           (halt),
		.rt             (in_instr[20:16]),
		.rd             (in_instr[15:11]),
		.shamt          (in_instr[10:6]),
		.rdat1          (rdat1),
		.rdat2          (rdat2),
		.imm_ext        (imm_ext),
		.in_ready       (in_ready),
		.out_valid      (out_valid),
		.halted         (),
		.alu_op_id_ex   (alu_op_id_ex),
		.alu_src_id_ex  (alu_src_id_ex),
		.reg_dest_id_ex (reg_dest_id_ex),
		.wen_id_ex      (out_wen),
		.halt_id_ex     (out_halt),
		.rt_id_ex       (rt_id_ex),
		.rd_id_ex       (rd_id_ex),
		.shamt_id_ex    (shamt_id_ex),
		.rdat1_id_ex    (rdat1_id_ex),
		.rdat2_id_ex    (rdat2_id_ex),
		.imm_ext_id_ex  (imm_ext_id_ex)
	);

	alu u_alu (
		.alu_op   (alu_op_id_ex),
		.alu_src  (alu_src_id_ex),
		.reg_dest (reg_dest_id_ex),
		.rdat1    (rdat1_id_ex),
		.rdat2    (rdat2_id_ex),
		.imm_ext  (imm_ext_id_ex),
		.rt       (rt_id_ex),
		.rd       (rd_id_ex),
		.shamt    (shamt_id_ex),
		.result   (out_result),
		.dest     (out_dest)
	);

endmodule

/* test/mips_id_ex_tb.sv */
`timescale 1ns/1ps

module mips_id_ex_tb import cpu_types_pkg::*; ();

	localparam int wait_limit = 50;
	localparam int mode_high = 0;
	localparam int mode_random = 1;
	localparam int mode_low = 2;

	typedef struct packed {
		word_t    result;
		regbits_t dest;
		logic     wen;
		logic     halt;
	} expect_t;

	logic CLK;
	logic nRST;
	logic in_valid;
	logic in_ready;
	word_t in_instr;
	logic out_valid;
	logic out_ready;
	word_t out_result;
	regbits_t out_dest;
	logic out_wen;
	logic out_halt;
	logic flush;

	word_t ref_regs [32];
	expect_t exp_q [$];
	expect_t exp_head;
	logic exp_valid = 1'b0;
	logic halt_seen = 1'b0;
	int accept_count = 0;
	int xfer_count = 0;
	int flush_count = 0;
	int ready_mode = 0;
	int seed = 61409;

	funct_t funct_list [10] = '{ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL};
	opcode_t imm_list [6] = '{ADDIU, SLTI, ANDI, ORI, XORI, LUI};

	mips_id_ex UUT (
		.CLK        (CLK),
		.nRST       (nRST),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_instr   (in_instr),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result),
		.out_dest   (out_dest),
		.out_wen    (out_wen),
		.out_halt   (out_halt),
		.flush      (flush)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// Moves to the next falling edge and drives out_ready for the current mode
	task automatic tick();
		logic [31:0] rnd;
		@(negedge CLK);
		rnd = $random(seed);
		if (ready_mode == mode_high) begin
			out_ready = 1'b1;
		end else if (ready_mode == mode_random) begin
			out_ready = rnd[0];
		end else begin
			out_ready = 1'b0;
		end
	endtask

	task automatic send_instr(input word_t instr);
		int start;
		int n;
		start = accept_count;
		n = 0;
		in_valid = 1'b1;
		in_instr = instr;
		while (accept_count == start) begin
			tick();
			n++;
			if (n > wait_limit) begin
				stop_on_error("input handshake timed out");
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (out_valid) begin
			tick();
			n++;
			if (n > wait_limit) begin
				stop_on_error("output did not drain before the timeout");
			end
		end
	endtask

	function automatic int rand_below(input int limit);
		return $unsigned($random(seed)) % limit;
	endfunction

	function automatic word_t enc_r(input funct_t fn, input regbits_t rs, input regbits_t rt,
		input regbits_t rd, input logic [4:0] shamt);
		return {RTYPE, rs, rt, rd, shamt, fn};
	endfunction

	function automatic word_t enc_i(input opcode_t op, input regbits_t rs, input regbits_t rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Small register range so that neighbouring instructions often depend on each other
	function automatic word_t random_instr();
		int pick;
		regbits_t rs;
		regbits_t rt;
		regbits_t rd;
		logic [4:0] shamt;
		logic [15:0] imm;
		word_t instr;
		pick = rand_below(16);
		rs = 5'(rand_below(8));
		rt = 5'(rand_below(8));
		rd = 5'(rand_below(8));
		shamt = 5'(rand_below(32));
		imm = 16'(rand_below(65536));
		if (pick < 10) begin
			instr = enc_r(funct_list[pick], rs, rt, rd, shamt);
		end else begin
			instr = enc_i(imm_list[pick - 10], rs, rt, imm);
		end
		return instr;
	endfunction

	// Expected outcome of one instruction against the reference registers
	function automatic expect_t model_instr(input word_t instr);
		expect_t e;
		word_t a;
		word_t b;
		word_t simm;
		word_t zimm;
		a = ref_regs[instr[25:21]];
		b = ref_regs[instr[20:16]];
		simm = {{16{instr[15]}}, instr[15:0]};
		zimm = {16'h0000, instr[15:0]};
		e.result = '0;
		e.dest = instr[20:16]; // I-types write rt
		e.wen = 1'b1;
		e.halt = 1'b0;
		case (instr[31:26])
			RTYPE: begin
				e.dest = instr[15:11];
				case (instr[5:0])
					ADDU: e.result = a + b;
					SUBU: e.result = a - b;
					AND:  e.result = a & b;
					OR:   e.result = a | b;
					XOR:  e.result = a ^ b;
					NOR:  e.result = ~(a | b);
					SLT:  e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					SLTU: e.result = (a < b) ? 32'd1 : 32'd0;
					SLL:  e.result = b << instr[10:6];
					SRL:  e.result = b >> instr[10:6];
					default: e.wen = 1'b0;
				endcase
			end
			ADDIU: e.result = a + simm;
			SLTI:  e.result = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
			ANDI:  e.result = a & zimm;
			ORI:   e.result = a | zimm;
			XORI:  e.result = a ^ zimm;
			LUI:   e.result = {instr[15:0], 16'h0000};
			HALT: begin
				e.wen = 1'b0;
				e.halt = 1'b1;
			end
			default: e.wen = 1'b0;
		endcase
		return e;
	endfunction

	always @(posedge CLK) begin : scoreboard
		expect_t e;
		if (!nRST) begin
			for (int i = 0; i < 32; i++) begin
				ref_regs[i] = '0;
			end
			exp_q.delete();
			exp_valid <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			if (out_valid && out_ready) begin
				output_expected: assert (exp_q.size() > 0)
					else stop_on_error("an output transferred with nothing outstanding");
				e = exp_q.pop_front();
				if (e.wen && (e.dest != '0)) begin
					ref_regs[e.dest] = e.result; // Register 0 keeps its zero
				end
				if (e.halt) begin
					halt_seen <= 1'b1;
				end
				xfer_count++;
			end else if (flush && out_valid) begin
				e = exp_q.pop_front(); // Squashed, so the model is not written
				flush_count++;
			end
			// Write-back above runs first to mirror the register file bypass
			if (in_valid && in_ready) begin
				exp_q.push_back(model_instr(in_instr));
				accept_count++;
				single_held: assert (exp_q.size() == 1)
					else stop_on_error("more than one instruction is held at once");
			end
			exp_valid <= (exp_q.size() > 0);
			if (exp_q.size() > 0) begin
				exp_head <= exp_q[0];
			end
		end
	end

	reset_outputs: assert property (@(posedge CLK)
		$rose(nRST) |-> (!out_valid && !out_wen && !out_halt && in_ready))
		else stop_on_error("outputs were not idle after reset");

	valid_matches: assert property (@(posedge CLK) disable iff (!nRST)
		out_valid == exp_valid)
		else stop_on_error($sformatf("error out_valid: got %h expected %h",
			$sampled(out_valid), $sampled(exp_valid)));

	result_matches: assert property (@(posedge CLK) disable iff (!nRST)
		(out_valid && exp_valid && exp_head.wen) |-> (out_result == exp_head.result))
		else stop_on_error($sformatf("error out_result: got %h expected %h",
			$sampled(out_result), $sampled(exp_head.result)));

	dest_matches: assert property (@(posedge CLK) disable iff (!nRST)
		(out_valid && exp_valid && exp_head.wen) |-> (out_dest == exp_head.dest))
		else stop_on_error($sformatf("error out_dest: got %h expected %h",
			$sampled(out_dest), $sampled(exp_head.dest)));

	wen_matches: assert property (@(posedge CLK) disable iff (!nRST)
		(out_valid && exp_valid) |-> (out_wen == exp_head.wen))
		else stop_on_error($sformatf("error out_wen: got %h expected %h",
			$sampled(out_wen), $sampled(exp_head.wen)));

	halt_matches: assert property (@(posedge CLK) disable iff (!nRST)
		(out_valid && exp_valid) |-> (out_halt == exp_head.halt))
		else stop_on_error($sformatf("error out_halt: got %h expected %h",
			$sampled(out_halt), $sampled(exp_head.halt)));

	stall_blocks_input: assert property (@(posedge CLK) disable iff (!nRST)
		(out_valid && !out_ready) |-> !in_ready)
		else stop_on_error("input was ready while the output was stalled");

	stall_holds_output: assert property (@(posedge CLK) disable iff (!nRST)
		(out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_result)
			&& $stable(out_dest) && $stable(out_wen) && $stable(out_halt)))
		else stop_on_error("the output changed while it was stalled");

	flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
		(flush && out_valid && !out_ready) |=> !out_valid)
		else stop_on_error("the held instruction survived a flush");

	halt_closes_input: assert property (@(posedge CLK) disable iff (!nRST)
		halt_seen |-> (!in_ready && !out_valid))
		else stop_on_error("the slice kept working after HALT left it");

	initial begin
		int n;
		nRST = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		out_ready = 1'b0;
		flush = 1'b0;
		repeat (2) @(negedge CLK);
		nRST = 1'b1;
		tick();

		send_instr(enc_i(ADDIU, 5'd0, 5'd1, 16'h8000)); // Sign extends to ffff8000
		send_instr(enc_i(ORI, 5'd0, 5'd2, 16'h8001)); // Zero extends to 00008001
		send_instr(enc_i(LUI, 5'd0, 5'd3, 16'h1234));
		send_instr(enc_i(XORI, 5'd3, 5'd4, 16'hffff));
		send_instr(enc_i(ANDI, 5'd1, 5'd5, 16'hf0f0));
		send_instr(enc_i(SLTI, 5'd1, 5'd6, 16'h0005)); // Negative operand compares signed
		send_instr(enc_i(SLTI, 5'd2, 5'd7, 16'hffff));
		send_instr(enc_i(ADDIU, 5'd1, 5'd0, 16'h0001)); // Aimed at register 0
		send_instr(enc_r(ADDU, 5'd1, 5'd2, 5'd8, 5'd0)); // Dependent chain starts here
		send_instr(enc_r(ADDU, 5'd8, 5'd8, 5'd9, 5'd0));
		send_instr(enc_r(SUBU, 5'd9, 5'd0, 5'd10, 5'd0));
		send_instr(enc_r(SLL, 5'd0, 5'd10, 5'd10, 5'd4));
		send_instr(enc_r(SRL, 5'd0, 5'd10, 5'd11, 5'd7));

		repeat (60) send_instr(random_instr());
		ready_mode = mode_random; // Back-pressure at random from here
		repeat (60) send_instr(random_instr());

		ready_mode = mode_high;
		drain();
		ready_mode = mode_low;
		tick();
		send_instr(enc_r(ADDU, 5'd1, 5'd2, 5'd12, 5'd0));
		flush = 1'b1; // Squash it while it is stalled
		tick();
		flush = 1'b0;
		ready_mode = mode_high;
		tick();
		send_instr(enc_r(ADDU, 5'd12, 5'd0, 5'd13, 5'd0)); // Sees r12 unwritten
		send_instr({6'h23, 5'd1, 5'd13, 16'h0004}); // Unknown opcode becomes a bubble

		send_instr({HALT, 26'h0});
		drain();
		n = accept_count;
		in_valid = 1'b1;
		in_instr = enc_r(ADDU, 5'd1, 5'd1, 5'd14, 5'd0);
		repeat (20) tick();
		in_valid = 1'b0;
		halt_blocks_input: assert (accept_count == n)
			else stop_on_error("an instruction was accepted after HALT");

		if ((exp_q.size() == 0) && (accept_count == xfer_count + flush_count)
			&& halt_seen) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			stop_on_error("instructions were lost or HALT never left the slice");
		end
	end

endmodule

/* mips_id_ex.f */
+incdir+common
common/cpu_types_pkg.sv
decode/control_unit.sv
decode/register_file.sv
logic/id_ex_reg.sv
logic/alu.sv
logic/mips_id_ex.sv
test/mips_id_ex_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_id_ex_tb -f mips_id_ex.f

output=$(./obj_dir/Vmips_id_ex_tb || true)
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
